// File: ht_node_pkg.sv
package ht_node_pkg;

  // index width covers symbols and internal nodes in 128 tree entries
  localparam int IDX_W = 7;
  localparam int WT_W  = 16;

  // leaf refs carry a symbol and sum refs an internal node number
  typedef struct packed {
    logic             is_sum;
    logic [IDX_W-1:0] idx;
  } node_ref_t;

  // one 39-bit tree memory entry
  typedef struct packed {
    logic [IDX_W-1:0] self_idx;
    node_ref_t        left;
    node_ref_t        right;
    logic [WT_W-1:0]  weight;
  } tree_rec_t;

  localparam int REF_W = $bits(node_ref_t);
  localparam int REC_W = $bits(tree_rec_t);

endpackage

// File: ht_ctrl_pkg.sv
package ht_ctrl_pkg;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_COUNT,
    PH_BUILD
  } phase_t;

  // broadcast operations to the weight cells
  typedef enum logic [2:0] {
    CELL_NOP,
    CELL_CLEAR,
    CELL_INC,
    CELL_LOAD,
    CELL_RETIRE
  } cell_op_t;

  typedef enum logic [3:0] {
    B_IDLE,
    B_SCAN,
    B_NEWNODE,
    B_L1_READ,
    B_L1_NULL,
    B_L2_READ,
    B_L2_NULL,
    B_MERGE,
    B_FIN
  } build_state_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_DONE
  } scan_state_t;

endpackage

// File: ht_weight_cell.sv
`timescale 1ns/1ps

module ht_weight_cell #(
  parameter int SYM_W = 3
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [SYM_W-1:0]                 slot,
  input  ht_ctrl_pkg::cell_op_t            cell_op,
  input  logic [SYM_W-1:0]                 cell_sel,
  input  ht_node_pkg::node_ref_t           cell_ref,
  input  logic [ht_node_pkg::WT_W-1:0]     cell_wt,
  output logic                             live,
  output logic [ht_node_pkg::WT_W-1:0]     wt,
  output ht_node_pkg::node_ref_t           nref
);

  logic                   hit;
  ht_node_pkg::node_ref_t leaf_ref;

  assign hit = (cell_sel == slot);

  // leaf for this slot is its own symbol
  assign leaf_ref.is_sum = 1'b0;
  assign leaf_ref.idx    = {{(ht_node_pkg::IDX_W - SYM_W){1'b0}}, slot};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live <= 1'b0;
      wt   <= '0;
      nref <= leaf_ref;
    end else begin
      case (cell_op)
        ht_ctrl_pkg::CELL_CLEAR: begin
          live <= 1'b0;
          wt   <= '0;
          nref <= leaf_ref;
        end
        ht_ctrl_pkg::CELL_INC: begin
          if (hit) begin
            live <= 1'b1;
            wt   <= wt + 1'b1;
          end
        end
        ht_ctrl_pkg::CELL_LOAD: begin
          if (hit) begin
            nref <= cell_ref;
            wt   <= cell_wt;
          end
        end
        ht_ctrl_pkg::CELL_RETIRE: begin
          if (hit) live <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // a frame longer than the weight range would corrupt the tree
  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (cell_op == ht_ctrl_pkg::CELL_INC && hit) |-> (wt != '1));

  // merges only land on slots the scan reported as live
  a_load_live: assert property (@(posedge clk) disable iff (!rst_n)
    (cell_op == ht_ctrl_pkg::CELL_LOAD && hit) |-> live);

endmodule

// File: ht_cell_feeder.sv
`timescale 1ns/1ps

module ht_cell_feeder #(
  parameter int SYM_W = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          sym_valid,
  input  logic [SYM_W-1:0]              sym,
  input  logic                          sym_last,
  input  logic                          build_end,
  input  logic                          merge_req,
  input  logic [SYM_W-1:0]              slot_a,
  input  logic [SYM_W-1:0]              slot_b,
  input  ht_node_pkg::node_ref_t        sum_ref,
  input  logic [ht_node_pkg::WT_W-1:0]  sum_wt,
  output logic                          sym_ready,
  output logic                          build_go,
  output logic                          merge_ack,
  output ht_ctrl_pkg::cell_op_t         cell_op,
  output logic [SYM_W-1:0]              cell_sel,
  output ht_node_pkg::node_ref_t        cell_ref,
  output logic [ht_node_pkg::WT_W-1:0]  cell_wt
);

  ht_ctrl_pkg::phase_t phase;
  logic                sym_xfer;
  logic                merge_step;
  logic                in_build;

  assign sym_ready = (phase == ht_ctrl_pkg::PH_COUNT);
  assign in_build  = (phase == ht_ctrl_pkg::PH_BUILD);
  assign sym_xfer  = sym_valid & sym_ready;
  assign build_go  = sym_xfer & sym_last;
  // the retire in the second merge cycle carries the ack
  assign merge_ack = merge_step;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= ht_ctrl_pkg::PH_IDLE;
      merge_step <= 1'b0;
    end else begin
      merge_step <= merge_req & in_build & ~merge_step;
      case (phase)
        ht_ctrl_pkg::PH_IDLE:  if (start) phase <= ht_ctrl_pkg::PH_COUNT;
        ht_ctrl_pkg::PH_COUNT: if (build_go) phase <= ht_ctrl_pkg::PH_BUILD;
        ht_ctrl_pkg::PH_BUILD: if (build_end) phase <= ht_ctrl_pkg::PH_IDLE;
        default:               phase <= ht_ctrl_pkg::PH_IDLE;
      endcase
    end
  end

  always_comb begin
    cell_op  = ht_ctrl_pkg::CELL_NOP;
    cell_sel = sym;
    cell_ref = sum_ref;
    cell_wt  = sum_wt;
    if (phase == ht_ctrl_pkg::PH_IDLE && start) begin
      cell_op = ht_ctrl_pkg::CELL_CLEAR;
    end else if (sym_xfer) begin
      cell_op = ht_ctrl_pkg::CELL_INC;
    end else if (merge_step) begin
      cell_op  = ht_ctrl_pkg::CELL_RETIRE;
      cell_sel = slot_b;
    end else if (merge_req && in_build) begin
      cell_op  = ht_ctrl_pkg::CELL_LOAD;
      cell_sel = slot_a;
    end
  end

  a_merge_in_build: assert property (@(posedge clk) disable iff (!rst_n)
    merge_req |-> in_build);

endmodule

// File: ht_min_select.sv
`timescale 1ns/1ps

module ht_min_select #(
  parameter int N_SYM = 8,
  parameter int SYM_W = 3
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      scan_go,
  input  logic [N_SYM-1:0]                          live,
  input  logic [N_SYM-1:0][ht_node_pkg::WT_W-1:0]   wt,
  input  ht_node_pkg::node_ref_t [N_SYM-1:0]        nref,
  output logic                                      pair_valid,
  output logic                                      few_live,
  output logic [SYM_W-1:0]                          l1_slot,
  output logic [SYM_W-1:0]                          l2_slot,
  output ht_node_pkg::node_ref_t                    l1_ref,
  output ht_node_pkg::node_ref_t                    l2_ref,
  output logic [ht_node_pkg::WT_W-1:0]              l1_wt,
  output logic [ht_node_pkg::WT_W-1:0]              l2_wt
);

  ht_ctrl_pkg::scan_state_t     state;
  logic [SYM_W-1:0]             cnt;
  logic                         l1_v;
  logic                         l2_v;
  logic [ht_node_pkg::WT_W-1:0] cur_wt;
  logic                         take1;
  logic                         take2;

  assign cur_wt = wt[cnt];
  // strict compares keep the earlier slot on ties
  assign take1 = (state == ht_ctrl_pkg::S_RUN) && live[cnt] && (!l1_v || cur_wt < l1_wt);
  assign take2 = (state == ht_ctrl_pkg::S_RUN) && live[cnt] && !take1 &&
                 (!l2_v || cur_wt < l2_wt);

  assign pair_valid = (state == ht_ctrl_pkg::S_DONE);
  assign few_live   = ~l2_v;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ht_ctrl_pkg::S_IDLE;
      cnt   <= '0;
      l1_v  <= 1'b0;
      l2_v  <= 1'b0;
    end else begin
      case (state)
        ht_ctrl_pkg::S_IDLE: begin
          if (scan_go) begin
            cnt   <= '0;
            l1_v  <= 1'b0;
            l2_v  <= 1'b0;
            state <= ht_ctrl_pkg::S_RUN;
          end
        end
        ht_ctrl_pkg::S_RUN: begin
          if (take1) begin
            l1_v <= 1'b1;
            l2_v <= l1_v;
          end else if (take2) begin
            l2_v <= 1'b1;
          end
          cnt <= cnt + 1'b1;
          if (cnt == {SYM_W{1'b1}}) state <= ht_ctrl_pkg::S_DONE;
        end
        default: state <= ht_ctrl_pkg::S_IDLE;
      endcase
    end
  end

  // running best and second best
  always_ff @(posedge clk) begin
    if (take1) begin
      l2_slot <= l1_slot;
      l2_ref  <= l1_ref;
      l2_wt   <= l1_wt;
      l1_slot <= cnt;
      l1_ref  <= nref[cnt];
      l1_wt   <= cur_wt;
    end else if (take2) begin
      l2_slot <= cnt;
      l2_ref  <= nref[cnt];
      l2_wt   <= cur_wt;
    end
  end

endmodule

// File: ht_node_builder.sv
`timescale 1ns/1ps

module ht_node_builder #(
  parameter int SYM_W = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          build_go,
  input  logic                          pair_valid,
  input  logic                          few_live,
  input  logic [SYM_W-1:0]              l1_slot,
  input  logic [SYM_W-1:0]              l2_slot,
  input  ht_node_pkg::node_ref_t        l1_ref,
  input  ht_node_pkg::node_ref_t        l2_ref,
  input  logic [ht_node_pkg::WT_W-1:0]  l1_wt,
  input  logic [ht_node_pkg::WT_W-1:0]  l2_wt,
  input  logic                          merge_ack,
  input  ht_node_pkg::tree_rec_t        b_dat_r,
  input  logic                          b_ack,
  output logic                          scan_go,
  output logic                          merge_req,
  output logic [SYM_W-1:0]              slot_a,
  output logic [SYM_W-1:0]              slot_b,
  output ht_node_pkg::node_ref_t        sum_ref,
  output logic [ht_node_pkg::WT_W-1:0]  sum_wt,
  output logic                          build_end,
  output logic                          build_done,
  output logic [ht_node_pkg::IDX_W-1:0] node_count,
  output logic                          b_cyc,
  output logic                          b_stb,
  output logic                          b_we,
  output logic [ht_node_pkg::IDX_W-1:0] b_adr,
  output ht_node_pkg::tree_rec_t        b_dat_w
);

  ht_ctrl_pkg::build_state_t    state;
  ht_ctrl_pkg::build_state_t    after_bus;
  ht_node_pkg::node_ref_t       p1_ref;
  ht_node_pkg::node_ref_t       p2_ref;
  logic [ht_node_pkg::WT_W-1:0] p1_wt;
  logic [ht_node_pkg::WT_W-1:0] p2_wt;
  ht_node_pkg::tree_rec_t       child_rec;
  ht_node_pkg::tree_rec_t       req_dat;
  logic [ht_node_pkg::IDX_W-1:0] req_adr;
  logic                         req_we;
  logic                         bus_state;

  assign sum_ref.is_sum = 1'b1;
  assign sum_ref.idx    = node_count;
  assign sum_wt         = p1_wt + p2_wt;
  assign merge_req      = (state == ht_ctrl_pkg::B_MERGE);

  // address, data and follow-up state of the current bus step
  always_comb begin
    bus_state = 1'b1;
    req_we    = 1'b1;
    req_adr   = node_count;
    req_dat   = child_rec;
    req_dat.weight = '0;
    after_bus = ht_ctrl_pkg::B_MERGE;
    case (state)
      ht_ctrl_pkg::B_NEWNODE: begin
        req_dat = '{self_idx: node_count, left: p1_ref, right: p2_ref, weight: sum_wt};
        if (p1_ref.is_sum)      after_bus = ht_ctrl_pkg::B_L1_READ;
        else if (p2_ref.is_sum) after_bus = ht_ctrl_pkg::B_L2_READ;
      end
      ht_ctrl_pkg::B_L1_READ: begin
        req_we    = 1'b0;
        req_adr   = p1_ref.idx;
        after_bus = ht_ctrl_pkg::B_L1_NULL;
      end
      ht_ctrl_pkg::B_L1_NULL: begin
        req_adr = p1_ref.idx;
        if (p2_ref.is_sum) after_bus = ht_ctrl_pkg::B_L2_READ;
      end
      ht_ctrl_pkg::B_L2_READ: begin
        req_we    = 1'b0;
        req_adr   = p2_ref.idx;
        after_bus = ht_ctrl_pkg::B_L2_NULL;
      end
      ht_ctrl_pkg::B_L2_NULL: req_adr = p2_ref.idx;
      default:                bus_state = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ht_ctrl_pkg::B_IDLE;
      scan_go    <= 1'b0;
      build_end  <= 1'b0;
      build_done <= 1'b0;
      node_count <= '0;
      b_cyc      <= 1'b0;
      b_stb      <= 1'b0;
    end else begin
      scan_go   <= 1'b0;
      build_end <= 1'b0;
      if (bus_state && !b_cyc) begin
        b_cyc <= 1'b1;
        b_stb <= 1'b1;
      end else if (b_ack) begin
        b_cyc <= 1'b0;
        b_stb <= 1'b0;
        state <= after_bus;
      end
      case (state)
        ht_ctrl_pkg::B_IDLE: begin
          if (build_go) begin
            node_count <= '0;
            build_done <= 1'b0;
            scan_go    <= 1'b1;
            state      <= ht_ctrl_pkg::B_SCAN;
          end
        end
        ht_ctrl_pkg::B_SCAN: begin
          if (pair_valid) begin
            state <= few_live ? ht_ctrl_pkg::B_FIN : ht_ctrl_pkg::B_NEWNODE;
          end
        end
        ht_ctrl_pkg::B_MERGE: begin
          if (merge_ack) begin
            node_count <= node_count + 1'b1;
            scan_go    <= 1'b1;
            state      <= ht_ctrl_pkg::B_SCAN;
          end
        end
        ht_ctrl_pkg::B_FIN: begin
          build_done <= 1'b1;
          build_end  <= 1'b1;
          state      <= ht_ctrl_pkg::B_IDLE;
        end
        default: ;
      endcase
    end
  end

  // pair, child record and bus payload
  always_ff @(posedge clk) begin
    if (state == ht_ctrl_pkg::B_SCAN && pair_valid) begin
      slot_a <= l1_slot;
      slot_b <= l2_slot;
      p1_ref <= l1_ref;
      p2_ref <= l2_ref;
      p1_wt  <= l1_wt;
      p2_wt  <= l2_wt;
    end
    if (b_ack && !b_we) child_rec <= b_dat_r;
    if (bus_state && !b_cyc) begin
      b_we    <= req_we;
      b_adr   <= req_adr;
      b_dat_w <= req_dat;
    end
  end

  // the memory only acks a strobe that is still up
  a_ack_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    b_ack |-> (b_cyc && b_stb));

endmodule

// File: ht_tree_mem.sv
`timescale 1ns/1ps

module ht_tree_mem (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          build_done,
  input  logic                          b_cyc,
  input  logic                          b_stb,
  input  logic                          b_we,
  input  logic [ht_node_pkg::IDX_W-1:0] b_adr,
  input  ht_node_pkg::tree_rec_t        b_dat_w,
  output ht_node_pkg::tree_rec_t        b_dat_r,
  output logic                          b_ack,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic [ht_node_pkg::IDX_W-1:0] wb_adr,
  output ht_node_pkg::tree_rec_t        wb_dat_r,
  output logic                          wb_ack
);

  ht_node_pkg::tree_rec_t mem [2**ht_node_pkg::IDX_W];
  logic                   b_take;
  logic                   wb_take;

  // builder has priority and the host is served only on a finished tree
  assign b_take  = b_cyc & b_stb & ~b_ack;
  assign wb_take = wb_cyc & wb_stb & ~wb_ack & ~b_cyc & build_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_ack  <= 1'b0;
      wb_ack <= 1'b0;
    end else begin
      b_ack  <= b_take;
      wb_ack <= wb_take;
    end
  end

  always_ff @(posedge clk) begin
    if (b_take) begin
      if (b_we) mem[b_adr] <= b_dat_w;
      else      b_dat_r    <= mem[b_adr];
    end
    if (wb_take) wb_dat_r <= mem[wb_adr];
  end

  // host holds its request until the ack
  a_host_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: ht_top.sv
`timescale 1ns/1ps

module ht_top #(
  parameter int N_SYM = 8,
  parameter int SYM_W = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          sym_valid,
  output logic                          sym_ready,
  input  logic [SYM_W-1:0]              sym,
  input  logic                          sym_last,
  output logic                          build_done,
  output logic [ht_node_pkg::IDX_W-1:0] node_count,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic [ht_node_pkg::IDX_W-1:0] wb_adr,
  output ht_node_pkg::tree_rec_t        wb_dat_r,
  output logic                          wb_ack
);

  ht_ctrl_pkg::cell_op_t                  bc_op;
  logic [SYM_W-1:0]                       bc_sel;
  ht_node_pkg::node_ref_t                 bc_ref;
  logic [ht_node_pkg::WT_W-1:0]           bc_wt;
  logic [N_SYM-1:0]                       slot_live;
  logic [N_SYM-1:0][ht_node_pkg::WT_W-1:0] slot_wt;
  ht_node_pkg::node_ref_t [N_SYM-1:0]     slot_nref;

  logic build_go, build_end, bld_done, scan_go, pair_valid, few_live;
  logic merge_req, merge_ack;
  logic [SYM_W-1:0] l1_slot, l2_slot, slot_a, slot_b;
  ht_node_pkg::node_ref_t l1_ref, l2_ref, sum_ref;
  logic [ht_node_pkg::WT_W-1:0] l1_wt, l2_wt, sum_wt;

  logic b_cyc, b_stb, b_we, b_ack;
  logic [ht_node_pkg::IDX_W-1:0] b_adr;
  ht_node_pkg::tree_rec_t b_dat_w, b_dat_r;

  // a new frame in counting hides the previous done flag
  assign build_done = bld_done & ~sym_ready;

  ht_cell_feeder #(.SYM_W(SYM_W)) u_feeder (
    .clk, .rst_n, .start, .sym_valid, .sym, .sym_last, .build_end, .merge_req,
    .slot_a, .slot_b, .sum_ref, .sum_wt, .sym_ready, .build_go, .merge_ack,
    .cell_op(bc_op), .cell_sel(bc_sel), .cell_ref(bc_ref), .cell_wt(bc_wt)
  );

  for (genvar i = 0; i < N_SYM; i++) begin : g_cell
    ht_weight_cell #(.SYM_W(SYM_W)) u_cell (
      .clk, .rst_n, .slot(SYM_W'(i)),
      .cell_op(bc_op), .cell_sel(bc_sel), .cell_ref(bc_ref), .cell_wt(bc_wt),
      .live(slot_live[i]), .wt(slot_wt[i]), .nref(slot_nref[i])
    );
  end

  ht_min_select #(.N_SYM(N_SYM), .SYM_W(SYM_W)) u_min_select (
    .clk, .rst_n, .scan_go, .live(slot_live), .wt(slot_wt), .nref(slot_nref),
    .pair_valid, .few_live, .l1_slot, .l2_slot, .l1_ref, .l2_ref, .l1_wt, .l2_wt
  );

  ht_node_builder #(.SYM_W(SYM_W)) u_builder (
    .clk, .rst_n, .build_go, .pair_valid, .few_live, .l1_slot, .l2_slot,
    .l1_ref, .l2_ref, .l1_wt, .l2_wt, .merge_ack, .b_dat_r, .b_ack,
    .scan_go, .merge_req, .slot_a, .slot_b, .sum_ref, .sum_wt, .build_end,
    .build_done(bld_done), .node_count, .b_cyc, .b_stb, .b_we, .b_adr, .b_dat_w
  );

  ht_tree_mem u_tree_mem (
    .clk, .rst_n, .build_done,
    .b_cyc, .b_stb, .b_we, .b_adr, .b_dat_w, .b_dat_r, .b_ack,
    .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held over three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// File: ht_tb.sv
`timescale 1ns/1ps

module ht_tb;

  localparam int N_SYM       = 8;
  localparam int SYM_W       = 3;
  localparam int N_FRAMES    = 12;
  localparam int MAX_LEN     = 40;
  localparam int MAX_GAP     = 3;
  localparam int FRAME_CYC   = MAX_LEN * (MAX_GAP + 1);
  localparam int CYCLE_LIMIT = N_FRAMES * (FRAME_CYC + N_SYM * (N_SYM + 20) + 50);

  logic                          clk;
  logic                          rst_n;
  logic                          start;
  logic                          sym_valid;
  logic                          sym_ready;
  logic [SYM_W-1:0]              sym;
  logic                          sym_last;
  logic                          build_done;
  logic [ht_node_pkg::IDX_W-1:0] node_count;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic [ht_node_pkg::IDX_W-1:0] wb_adr;
  ht_node_pkg::tree_rec_t        wb_dat_r;
  logic                          wb_ack;

  integer seed;
  int     cycles;
  int     frame_len [N_FRAMES];
  logic [SYM_W-1:0] frame_syms [N_FRAMES][MAX_LEN];

  // model histogram, forest and expected tree
  logic                         m_live [N_SYM];
  logic [ht_node_pkg::WT_W-1:0] m_wt [N_SYM];
  ht_node_pkg::node_ref_t       m_ref [N_SYM];
  ht_node_pkg::tree_rec_t       exp_rec [2**ht_node_pkg::IDX_W];
  int                           exp_nc;
  int                           exp_distinct;

  tb_clk_gen u_clk_gen (.clk, .rst_n);

  ht_top #(.N_SYM(N_SYM), .SYM_W(SYM_W)) DUT (
    .clk, .rst_n, .start, .sym_valid, .sym_ready, .sym, .sym_last,
    .build_done, .node_count, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack
  );

  task automatic check_rec(input string name, input ht_node_pkg::tree_rec_t exp_v,
                           input ht_node_pkg::tree_rec_t act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input logic [ht_node_pkg::IDX_W-1:0] exp_v,
                             input logic [ht_node_pkg::IDX_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_wt(input string name, input logic [ht_node_pkg::WT_W-1:0] exp_v,
                          input logic [ht_node_pkg::WT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic rand_below(input int range, output int val);
    val = {$random(seed)} % range;
  endtask

  task automatic gen_frames;
    int f;
    int k;
    int v;
    int alpha;
    for (f = 0; f < N_FRAMES; f++) begin
      rand_below(MAX_LEN, v);
      frame_len[f] = v + 1;
      rand_below(N_SYM, v);
      alpha = v + 1;
      // one frame with a single symbol value
      if (f == 2) alpha = 1;
      for (k = 0; k < frame_len[f]; k++) begin
        rand_below(alpha, v);
        frame_syms[f][k] = v;
      end
    end
  endtask

  task automatic null_child(input ht_node_pkg::node_ref_t r);
    ht_node_pkg::tree_rec_t rec;
    if (r.is_sum) begin
      rec = exp_rec[r.idx];
      rec.weight = '0;
      exp_rec[r.idx] = rec;
    end
  endtask

  task automatic build_model(input int f);
    int i;
    int k;
    int l1;
    int l2;
    logic busy;
    logic [SYM_W-1:0] s;
    ht_node_pkg::node_ref_t r;
    ht_node_pkg::tree_rec_t rec;
    for (i = 0; i < N_SYM; i++) begin
      m_live[i] = 1'b0;
      m_wt[i]   = '0;
      r.is_sum  = 1'b0;
      r.idx     = i;
      m_ref[i]  = r;
    end
    for (k = 0; k < frame_len[f]; k++) begin
      s = frame_syms[f][k];
      m_live[s] = 1'b1;
      m_wt[s]   = m_wt[s] + 1'b1;
    end
    exp_distinct = 0;
    for (i = 0; i < N_SYM; i++) begin
      if (m_live[i]) exp_distinct++;
    end
    exp_nc = 0;
    busy = 1'b1;
    while (busy) begin
      // lightest live slot where the lower slot wins a tie
      l1 = -1;
      for (i = 0; i < N_SYM; i++) begin
        if (m_live[i] && (l1 < 0 || m_wt[i] < m_wt[l1])) l1 = i;
      end
      l2 = -1;
      for (i = 0; i < N_SYM; i++) begin
        if (m_live[i] && i != l1 && (l2 < 0 || m_wt[i] < m_wt[l2])) l2 = i;
      end
      if (l2 < 0) begin
        busy = 1'b0;
      end else begin
        rec.self_idx = exp_nc;
        rec.left     = m_ref[l1];
        rec.right    = m_ref[l2];
        rec.weight   = m_wt[l1] + m_wt[l2];
        exp_rec[exp_nc] = rec;
        null_child(m_ref[l1]);
        null_child(m_ref[l2]);
        r.is_sum   = 1'b1;
        r.idx      = exp_nc;
        m_ref[l1]  = r;
        m_wt[l1]   = rec.weight;
        m_live[l2] = 1'b0;
        exp_nc++;
      end
    end
  endtask

  task automatic send_sym(input logic [SYM_W-1:0] s, input logic last);
    logic taken;
    taken     = 1'b0;
    sym_valid = 1'b1;
    sym       = s;
    sym_last  = last;
    while (!taken) begin
      @(negedge clk);
      taken = sym_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic host_read(input int addr, output ht_node_pkg::tree_rec_t data,
                           output logic done_seen);
    logic got;
    got    = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_adr = addr;
    while (!got) begin
      @(negedge clk);
      got = wb_ack;
    end
    data      = wb_dat_r;
    done_seen = build_done;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_build;
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      check_bit("sym_ready", 1'b0, sym_ready);
      seen = build_done;
    end
  endtask

  // start pulse and early host read while the build runs
  task automatic disturb_build;
    ht_node_pkg::tree_rec_t rec;
    logic done_seen;
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    check_bit("build_done", 1'b0, build_done);
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (exp_nc > 0) begin
      check_bit("build_done", 1'b0, build_done);
      host_read(0, rec, done_seen);
      check_bit("build_done at wb_ack", 1'b1, done_seen);
      check_rec("wb_dat_r @0", exp_rec[0], rec);
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("** FAIL **");
    $fatal(1);
  end

  initial begin
    int f;
    int k;
    int a;
    int gap;
    logic done_seen;
    ht_node_pkg::tree_rec_t rec;
    start     = 1'b0;
    sym_valid = 1'b0;
    sym       = '0;
    sym_last  = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_adr    = '0;
    seed      = 26;
    gen_frames();
    @(posedge rst_n);
    @(posedge clk);
    #1;

    // a host request must stall while idle after reset
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_bit("sym_ready", 1'b0, sym_ready);
      check_bit("build_done", 1'b0, build_done);
      check_bit("wb_ack", 1'b0, wb_ack);
    end
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;

    for (f = 0; f < N_FRAMES; f++) begin
      build_model(f);
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      check_bit("build_done", 1'b0, build_done);
      for (k = 0; k < frame_len[f]; k++) begin
        if (k > 0) begin
          rand_below(MAX_GAP + 1, gap);
          if (gap > 0) sym_valid = 1'b0;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
        end
        send_sym(frame_syms[f][k], k == frame_len[f] - 1);
      end
      // next frame's first symbol waits through the build
      if (f + 1 < N_FRAMES) begin
        sym_valid = 1'b1;
        sym       = frame_syms[f+1][0];
        sym_last  = (frame_len[f+1] == 1);
      end else begin
        sym_valid = 1'b0;
        sym_last  = 1'b0;
      end
      fork
        wait_build();
        if (f % 3 == 1) disturb_build();
      join
      @(posedge clk);
      #1;
      check_count("node_count", exp_distinct - 1, node_count);
      for (a = 0; a < exp_nc; a++) begin
        host_read(a, rec, done_seen);
        check_rec($sformatf("wb_dat_r @%0d", a), exp_rec[a], rec);
      end
      if (exp_nc > 0) check_wt("root weight", frame_len[f], rec.weight);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// File: ht_top.f
ht_node_pkg.sv
ht_ctrl_pkg.sv
ht_weight_cell.sv
ht_cell_feeder.sv
ht_min_select.sv
ht_node_builder.sv
ht_tree_mem.sv
ht_top.sv
tb_clk_gen.sv
ht_tb.sv
